/* scrypt_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrypt ROMix shared definitions
// Widths, scratchpad depth, round count, block types,
// controller state codes and the word/byte union
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package scrypt_pkg;

	localparam int SHIFT_BITS          = 8;	// Host shift lane, one byte
	localparam int WORD_BITS           = 32;	// Salsa word
	localparam int HALF_BITS           = 512;	// One BlockMix half (r = 1)
	localparam int BLOCK_BITS          = 1024;	// Whole ROMix state X
	localparam int SCRATCH_DEPTH       = 1024;	// Scrypt N
	localparam int SCRATCH_ADDR_BITS   = 10;
	localparam int SALSA_DOUBLE_ROUNDS = 4;	// Salsa20/8 is four column+row pairs
	localparam int INDEX_WORD          = 16;	// Integerify reads the first word of X1

	localparam int WORD_BYTES  = WORD_BITS / SHIFT_BITS;
	localparam int HALF_WORDS  = HALF_BITS / WORD_BITS;
	localparam int BLOCK_WORDS = BLOCK_BITS / WORD_BITS;

	// ROMix controller states
	localparam logic [2:0] ST_IDLE     = 3'd0;	// Waiting for start, result may be held
	localparam logic [2:0] ST_LOAD     = 3'd1;	// Datapath captures the shifted-in block
	localparam logic [2:0] ST_WRITE    = 3'd2;	// Fill the scratchpad
	localparam logic [2:0] ST_MIX_READ = 3'd3;	// Read address goes to the RAM
	localparam logic [2:0] ST_MIX      = 3'd4;	// BlockMix of X xor V[j]
	localparam logic [2:0] ST_STORE    = 3'd5;	// Hand X back to the shift register

	typedef logic [WORD_BITS-1:0]                    word_t;
	typedef logic [HALF_WORDS-1:0][WORD_BITS-1:0]    half_t;	// Word 0 in the low bits
	typedef logic [BLOCK_WORDS-1:0][WORD_BITS-1:0]   block_t;	// X0 in words 0..15, X1 above
	typedef logic [SCRATCH_ADDR_BITS-1:0]            scratch_addr_t;

	// Same 32 bits seen as a Salsa word or as its four bytes
	typedef union packed {
		word_t                                   word;
		logic [WORD_BYTES-1:0][SHIFT_BITS-1:0]   bytes;
	} salsa_word_u;

endpackage

/* block_shifter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host block shifter
// Byte-wide 1024-bit shift register shared by input and
// output, with byte-order conversion to scrypt words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module block_shifter (
	input  logic                              hash_clk,
	input  logic [scrypt_pkg::SHIFT_BITS-1:0] din,
	input  logic                              shift,
	input  logic                              store_block,
	input  scrypt_pkg::block_t                result_x,
	output logic [scrypt_pkg::SHIFT_BITS-1:0] dout,
	output scrypt_pkg::block_t                block_x
);
	import scrypt_pkg::*;

	logic [BLOCK_BITS-1:0] shift_reg;	// Slot i holds word i big-endian, as the host sent it
	logic [BLOCK_BITS-1:0] store_flat;	// result_x rearranged into shift register order

	// Reverse the bytes of one word, reading the union both ways
	function automatic word_t swap_bytes(input salsa_word_u w);
		salsa_word_u s;
		for (int b = 0; b < WORD_BYTES; b++)
			s.bytes[b] = w.bytes[WORD_BYTES - 1 - b];
		return s.word;
	endfunction

	assign dout = shift_reg[BLOCK_BITS-1 -: SHIFT_BITS];	// Top byte is always on view

	// The host sends big-endian bytes while scrypt works on little-endian words
	always_comb
	begin
		for (int i = 0; i < BLOCK_WORDS; i++)
		begin
			block_x[i] = swap_bytes(shift_reg[WORD_BITS*i +: WORD_BITS]);
			store_flat[WORD_BITS*i +: WORD_BITS] = swap_bytes(result_x[i]);	// Inverse mapping
		end
	end

	always_ff @(posedge hash_clk)
	begin
		if (shift)
			shift_reg <= {shift_reg[BLOCK_BITS-SHIFT_BITS-1:0], din};	// din enters at the bottom
		else if (store_block)
			shift_reg <= store_flat;	// A shift on the same edge wins
	end

endmodule

/* salsa_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Salsa20/8 core
// Iterative, one column+row double round per clock,
// feed-forward add applied on the output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module salsa_core (
	input  logic              hash_clk,
	input  logic              fsmreset,
	input  logic              salsa_go,
	input  scrypt_pkg::half_t salsa_in,
	output logic              salsa_done,
	output scrypt_pkg::half_t salsa_out
);
	import scrypt_pkg::*;

	half_t                                  work;	// Block being rounded
	half_t                                  feed;	// Copy of the input for the final add
	logic                                   running;
	logic [$clog2(SALSA_DOUBLE_ROUNDS)-1:0] round_cnt;	// Double rounds done so far

	function automatic word_t rotl(input word_t w, input int unsigned n);
		return (w << n) | (w >> (WORD_BITS - n));
	endfunction

	// Salsa quarter round on words a, b, c, d of the block
	function automatic half_t quarter(input half_t s, input int a, input int b,
		input int c, input int d);
		half_t t;
		t = s;
		t[b] = t[b] ^ rotl(t[a] + t[d], 7);
		t[c] = t[c] ^ rotl(t[b] + t[a], 9);
		t[d] = t[d] ^ rotl(t[c] + t[b], 13);
		t[a] = t[a] ^ rotl(t[d] + t[c], 18);
		return t;
	endfunction

	function automatic half_t double_round(input half_t s);
		half_t t;
		// Columns, each quarter starting on the diagonal
		t = quarter(s, 0, 4, 8, 12);
		t = quarter(t, 5, 9, 13, 1);
		t = quarter(t, 10, 14, 2, 6);
		t = quarter(t, 15, 3, 7, 11);
		// Rows
		t = quarter(t, 0, 1, 2, 3);
		t = quarter(t, 5, 6, 7, 4);
		t = quarter(t, 10, 11, 8, 9);
		t = quarter(t, 15, 12, 13, 14);
		return t;
	endfunction

	// Output stays valid until the next salsa_go since work and feed hold while idle
	always_comb
	begin
		for (int i = 0; i < HALF_WORDS; i++)
			salsa_out[i] = work[i] + feed[i];
	end

	always_ff @(posedge hash_clk)
	begin
		if (salsa_go)
		begin
			work <= salsa_in;
			feed <= salsa_in;
		end
		else if (running)
			work <= double_round(work);
	end

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			running    <= 1'b0;
			round_cnt  <= '0;
			salsa_done <= 1'b0;
		end
		else
		begin
			salsa_done <= 1'b0;	// Single-cycle pulse
			if (salsa_go)
			begin
				running   <= 1'b1;
				round_cnt <= '0;
			end
			else if (running)
			begin
				round_cnt <= round_cnt + 1'b1;
				if (round_cnt == SALSA_DOUBLE_ROUNDS - 1)
				begin
					running    <= 1'b0;
					salsa_done <= 1'b1;	// Lands 5 cycles after salsa_go
				end
			end
		end
	end

endmodule

/* mix_datapath.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BlockMix datapath
// Holds X0/X1 and runs the two Salsa20/8 calls of one
// BlockMix, optionally after xor with a scratchpad entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mix_datapath (
	input  logic                      hash_clk,
	input  logic                      fsmreset,
	input  logic                      load_block,
	input  logic                      mix_go,
	input  logic                      xor_ram,
	input  scrypt_pkg::block_t        block_x,
	input  scrypt_pkg::block_t        rd_data,
	output logic                      mix_done,
	output scrypt_pkg::block_t        x_state,
	output scrypt_pkg::scratch_addr_t scratch_index
);
	import scrypt_pkg::*;

	block_t x_reg;	// {X1, X0}
	half_t  x0;
	half_t  x1;
	half_t  x0_mix;	// X0 after the optional V[j] xor
	half_t  x1_mix;
	half_t  salsa_in;
	half_t  salsa_out;
	logic   salsa_go;
	logic   salsa_done;
	logic   second;	// Set while the X1 call is in flight

	assign x0 = x_reg[HALF_WORDS-1:0];
	assign x1 = x_reg[BLOCK_WORDS-1:HALF_WORDS];

	// RAM data is only meaningful in the mix_go cycle
	assign x0_mix = (mix_go && xor_ram) ? x0 ^ rd_data[HALF_WORDS-1:0] : x0;
	assign x1_mix = (mix_go && xor_ram) ? x1 ^ rd_data[BLOCK_WORDS-1:HALF_WORDS] : x1;

	// First call starts with mix_go, second one on the first call's done
	assign salsa_go = mix_go || (salsa_done && !second);
	assign salsa_in = mix_go ? (x0_mix ^ x1_mix) : (x1 ^ salsa_out);	// New X0 comes straight off the core

	salsa_core u_salsa_core (
		.hash_clk   (hash_clk),
		.fsmreset   (fsmreset),
		.salsa_go   (salsa_go),
		.salsa_in   (salsa_in),
		.salsa_done (salsa_done),
		.salsa_out  (salsa_out)
	);

	always_ff @(posedge hash_clk)
	begin
		if (load_block)
			x_reg <= block_x;
		else if (mix_go)
			x_reg <= {x1_mix, x0_mix};	// Keep the xored value for the second call
		else if (salsa_done && !second)
			x_reg[HALF_WORDS-1:0] <= salsa_out;
		else if (salsa_done)
			x_reg[BLOCK_WORDS-1:HALF_WORDS] <= salsa_out;
	end

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			second   <= 1'b0;
			mix_done <= 1'b0;
		end
		else
		begin
			mix_done <= 1'b0;
			if (mix_go)
				second <= 1'b0;
			else if (salsa_done)
			begin
				second   <= !second;
				mix_done <= second;	// X1 written on this edge so X is complete next cycle
			end
		end
	end

	assign x_state       = x_reg;
	assign scratch_index = x_reg[INDEX_WORD][SCRATCH_ADDR_BITS-1:0];	// Integerify, low bits only

endmodule

/* scratchpad_ram.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROMix scratchpad
// SCRATCH_DEPTH x 1024-bit RAM, registered read address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module scratchpad_ram (
	input  logic                      hash_clk,
	input  logic                      ram_wr,
	input  scrypt_pkg::scratch_addr_t wr_addr,
	input  scrypt_pkg::scratch_addr_t rd_addr,
	input  scrypt_pkg::block_t        wr_data,
	output scrypt_pkg::block_t        rd_data
);
	import scrypt_pkg::*;

	block_t        mem [SCRATCH_DEPTH];	// The V array of ROMix
	scratch_addr_t rd_addr_q;

	always_ff @(posedge hash_clk)
	begin
		if (ram_wr)
			mem[wr_addr] <= wr_data;
		rd_addr_q <= rd_addr;	// Data follows one cycle after the address
	end

	assign rd_data = mem[rd_addr_q];

endmodule

/* romix_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROMix controller
// Start/busy/result handshake, scratchpad write and
// mix phases, step counter and RAM addressing
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module romix_ctrl (
	input  logic                      hash_clk,
	input  logic                      fsmreset,
	input  logic                      start,
	input  logic                      mix_done,
	input  scrypt_pkg::scratch_addr_t scratch_index,
	output logic                      busy,
	output logic                      result,
	output logic                      load_block,
	output logic                      store_block,
	output logic                      mix_go,
	output logic                      xor_ram,
	output logic                      ram_wr,
	output scrypt_pkg::scratch_addr_t wr_addr,
	output scrypt_pkg::scratch_addr_t rd_addr
);
	import scrypt_pkg::*;

	logic [2:0]    state;
	scratch_addr_t step;	// Step index in the current phase
	logic          last_step;

	assign last_step = (step == scratch_addr_t'(SCRATCH_DEPTH - 1));

	// Write phase stores X at the step index, mix phase reads V[j]
	assign wr_addr = step;
	assign rd_addr = scratch_index;

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			state       <= ST_IDLE;
			step        <= '0;
			busy        <= 1'b0;
			result      <= 1'b0;
			load_block  <= 1'b0;
			store_block <= 1'b0;
			mix_go      <= 1'b0;
			xor_ram     <= 1'b0;
			ram_wr      <= 1'b0;
		end
		else
		begin
			// Strobes default low, set for one cycle below
			load_block  <= 1'b0;
			store_block <= 1'b0;
			mix_go      <= 1'b0;
			xor_ram     <= 1'b0;
			ram_wr      <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)	// Accepted with or without a result on hold
					begin
						load_block <= 1'b1;
						state      <= ST_LOAD;
					end
				end
				ST_LOAD:
				begin
					busy   <= 1'b1;	// Same edge as the datapath load
					result <= 1'b0;
					step   <= '0;
					ram_wr <= 1'b1;	// V[0] = loaded X, written as the first BlockMix starts
					mix_go <= 1'b1;
					state  <= ST_WRITE;
				end
				ST_WRITE:
				begin
					if (mix_done)
					begin
						if (last_step)
						begin
							step  <= '0;
							state <= ST_MIX_READ;
						end
						else
						begin
							step   <= step + 1'b1;
							ram_wr <= 1'b1;
							mix_go <= 1'b1;
						end
					end
				end
				ST_MIX_READ:
				begin
					// RAM takes scratch_index on this edge, data is there in ST_MIX
					mix_go  <= 1'b1;
					xor_ram <= 1'b1;
					state   <= ST_MIX;
				end
				ST_MIX:
				begin
					if (mix_done)
					begin
						if (last_step)
						begin
							store_block <= 1'b1;
							state       <= ST_STORE;
						end
						else
						begin
							step  <= step + 1'b1;
							state <= ST_MIX_READ;	// New X gives the next j
						end
					end
				end
				ST_STORE:
				begin
					busy   <= 1'b0;	// Shift register takes X on this edge
					result <= 1'b1;
					state  <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* salsa_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrypt ROMix engine, single thread
// Connects shifter, controller, BlockMix datapath
// and scratchpad
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module salsa_engine (
	input  logic                              hash_clk,
	input  logic                              fsmreset,
	input  logic [scrypt_pkg::SHIFT_BITS-1:0] din,
	input  logic                              shift,
	input  logic                              start,
	output logic [scrypt_pkg::SHIFT_BITS-1:0] dout,
	output logic                              busy,
	output logic                              result
);
	import scrypt_pkg::*;

	block_t        block_x;	// Shift register in word order
	block_t        x_state;	// Current X, also the scratchpad write data and the result
	block_t        rd_data;
	scratch_addr_t scratch_index;
	scratch_addr_t wr_addr;
	scratch_addr_t rd_addr;
	logic          load_block;
	logic          store_block;
	logic          mix_go;
	logic          xor_ram;
	logic          mix_done;
	logic          ram_wr;

	block_shifter u_block_shifter (
		.hash_clk    (hash_clk),
		.din         (din),
		.shift       (shift),
		.store_block (store_block),
		.result_x    (x_state),
		.dout        (dout),
		.block_x     (block_x)
	);

	romix_ctrl u_romix_ctrl (
		.hash_clk      (hash_clk),
		.fsmreset      (fsmreset),
		.start         (start),
		.mix_done      (mix_done),
		.scratch_index (scratch_index),
		.busy          (busy),
		.result        (result),
		.load_block    (load_block),
		.store_block   (store_block),
		.mix_go        (mix_go),
		.xor_ram       (xor_ram),
		.ram_wr        (ram_wr),
		.wr_addr       (wr_addr),
		.rd_addr       (rd_addr)
	);

	mix_datapath u_mix_datapath (
		.hash_clk      (hash_clk),
		.fsmreset      (fsmreset),
		.load_block    (load_block),
		.mix_go        (mix_go),
		.xor_ram       (xor_ram),
		.block_x       (block_x),
		.rd_data       (rd_data),
		.mix_done      (mix_done),
		.x_state       (x_state),
		.scratch_index (scratch_index)
	);

	scratchpad_ram u_scratchpad_ram (
		.hash_clk (hash_clk),
		.ram_wr   (ram_wr),
		.wr_addr  (wr_addr),
		.rd_addr  (rd_addr),
		.wr_data  (x_state),
		.rd_data  (rd_data)
	);

endmodule

/* salsa_engine_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrypt engine handshake assertions
// Bound into salsa_engine, checks shift/start/busy/result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module salsa_engine_assertions (
	input logic hash_clk,
	input logic fsmreset,
	input logic shift,
	input logic start,
	input logic busy,
	input logic result
);
	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;	// Assertion failures seen so far

	// The shift register is shared with the result, so the host keeps off it while hashing
	no_shift_while_busy: assert property (@(posedge hash_clk) disable iff (fsmreset)
		!(busy && shift))
		else
		begin
			$error("shift was high while busy was high");
			failures++;
		end

	// Result is cleared on the same edge that busy rises
	busy_result_exclusive: assert property (@(posedge hash_clk) disable iff (fsmreset)
		!(busy && result))
		else
		begin
			$error("busy and result were high together");
			failures++;
		end

	// Idle engine with start raised goes through load and then busy
	busy_follows_start: assert property (@(posedge hash_clk) disable iff (fsmreset)
		(start && !busy) |-> ##[1:2] busy)
		else
		begin
			$error("busy did not rise within two cycles of an accepted start");
			failures++;
		end

endmodule

bind salsa_engine salsa_engine_assertions u_salsa_engine_assertions (.*);

/* tb_salsa_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrypt ROMix engine testbench
// Directed tests against a reference ROMix model,
// with watchdog and closing error report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_salsa_engine;
	timeunit 1ns;
	timeprecision 1ps;

	import scrypt_pkg::*;

	localparam int     CLK_PERIOD  = 20;
	localparam int     NUM_BYTES   = BLOCK_BITS / SHIFT_BITS;	// 128 host bytes per block
	localparam int     NUM_HASHES  = 4;	// Zero, random, back-to-back and hold tests
	localparam int     HASH_CYCLES = SCRATCH_DEPTH * 2 * 16;	// Generous bound on one ROMix
	localparam longint WATCHDOG_NS = longint'(NUM_HASHES) * HASH_CYCLES * CLK_PERIOD + 200_000;

	// Salsa quarter rounds, four columns then four rows, as a, b, c, d word indices
	localparam int QR [8][4] = '{'{0, 4, 8, 12}, '{5, 9, 13, 1}, '{10, 14, 2, 6},
		'{15, 3, 7, 11}, '{0, 1, 2, 3}, '{5, 6, 7, 4}, '{10, 11, 8, 9}, '{15, 12, 13, 14}};

	typedef logic [SHIFT_BITS-1:0] byte_arr_t [NUM_BYTES];	// Index 0 is shifted first

	logic                  hash_clk;
	logic                  fsmreset;
	logic [SHIFT_BITS-1:0] din;
	logic                  shift;
	logic                  start;
	logic [SHIFT_BITS-1:0] dout;
	logic                  busy;
	logic                  result;

	int        seed;
	int        value_errors;	// Wrong values on busy, result or dout
	int        protocol_errors;	// Handshake never arrived
	block_t    model_v [SCRATCH_DEPTH];	// Reference scratchpad
	byte_arr_t in_bytes;
	byte_arr_t exp_bytes;

	salsa_engine dut_i (
		.hash_clk (hash_clk),
		.fsmreset (fsmreset),
		.din      (din),
		.shift    (shift),
		.start    (start),
		.dout     (dout),
		.busy     (busy),
		.result   (result)
	);

	always
	begin
		#(CLK_PERIOD / 2) hash_clk = ~hash_clk;
	end

	function automatic word_t rotl32(input word_t v, input int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// Salsa20/8 as in the scrypt paper, eight rounds then the feed-forward add
	function automatic half_t salsa20_8(input half_t b);
		half_t x;
		int    a;
		int    p;
		int    c;
		int    d;
		x = b;
		for (int r = 0; r < 8; r += 2)
		begin
			for (int q = 0; q < 8; q++)
			begin
				a = QR[q][0];
				p = QR[q][1];
				c = QR[q][2];
				d = QR[q][3];
				x[p] = x[p] ^ rotl32(x[a] + x[d], 7);
				x[c] = x[c] ^ rotl32(x[p] + x[a], 9);
				x[d] = x[d] ^ rotl32(x[c] + x[p], 13);
				x[a] = x[a] ^ rotl32(x[d] + x[c], 18);
			end
		end
		for (int i = 0; i < HALF_WORDS; i++)
			x[i] = x[i] + b[i];
		return x;
	endfunction

	// BlockMix with r = 1, Y0 from X0 ^ X1 and Y1 from X1 ^ Y0
	function automatic block_t block_mix(input block_t b);
		half_t y0;
		half_t y1;
		y0 = salsa20_8(b[HALF_WORDS-1:0] ^ b[BLOCK_WORDS-1:HALF_WORDS]);
		y1 = salsa20_8(b[BLOCK_WORDS-1:HALF_WORDS] ^ y0);
		return {y1, y0};
	endfunction

	function automatic block_t romix(input block_t b);
		block_t x;
		x = b;
		for (int i = 0; i < SCRATCH_DEPTH; i++)
		begin
			model_v[i] = x;
			x = block_mix(x);
		end
		for (int i = 0; i < SCRATCH_DEPTH; i++)
			x = block_mix(x ^ model_v[x[INDEX_WORD] % SCRATCH_DEPTH]);	// Integerify mod N
		return x;
	endfunction

	// Host byte 124-4i+t is byte t of little-endian word i, first byte lands in word 31
	function automatic block_t bytes_to_block(input byte_arr_t b);
		block_t      x;
		salsa_word_u u;
		for (int i = 0; i < BLOCK_WORDS; i++)
		begin
			for (int t = 0; t < WORD_BYTES; t++)
				u.bytes[t] = b[NUM_BYTES - WORD_BYTES * (i + 1) + t];
			x[i] = u.word;
		end
		return x;
	endfunction

	function automatic void block_to_bytes(input block_t x, output byte_arr_t b);
		salsa_word_u u;
		for (int i = 0; i < BLOCK_WORDS; i++)
		begin
			u.word = x[i];
			for (int t = 0; t < WORD_BYTES; t++)
				b[NUM_BYTES - WORD_BYTES * (i + 1) + t] = u.bytes[t];	// Same mapping back out
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic fill_random(output byte_arr_t b);
		for (int m = 0; m < NUM_BYTES; m++)
			b[m] = $random(seed);
	endtask

	task automatic shift_in_block(input byte_arr_t b);
		for (int m = 0; m < NUM_BYTES; m++)
		begin
			@(negedge hash_clk);
			din   = b[m];
			shift = 1'b1;
		end
		@(negedge hash_clk);
		shift = 1'b0;
		din   = '0;
	endtask

	// Reads dout before each shift, so the register is consumed
	task automatic shift_out_compare(input byte_arr_t expected);
		for (int m = 0; m < NUM_BYTES; m++)
		begin
			@(negedge hash_clk);
			if (dout !== expected[m])
			begin
				$display("ERROR %0t ns: dout byte %0d expected %h, got %h",
					$time, m, expected[m], dout);
				value_errors++;
			end
			shift = 1'b1;
		end
		@(negedge hash_clk);
		shift = 1'b0;
	endtask

	// Raise start, see busy rise with result cleared, then wait out the hash
	task automatic run_hash(input logic held_result);
		int cycles;
		@(negedge hash_clk);
		start  = 1'b1;
		cycles = 0;
		while (!busy && cycles < 4)
		begin
			@(negedge hash_clk);
			cycles++;
			if (!busy)
				check_value("result", held_result, result);	// Held until busy rises
		end
		start = 1'b0;	// Level start must drop or the engine would restart
		if (!busy)
		begin
			$display("Engine did not raise busy within 4 cycles of start");
			protocol_errors++;
			return;
		end
		check_value("result", 0, result);	// Falls on the edge busy rises
		cycles = 0;
		while (busy && cycles < HASH_CYCLES)
		begin
			@(negedge hash_clk);
			cycles++;
		end
		if (busy)
		begin
			$display("Engine stayed busy for %0d cycles without finishing", HASH_CYCLES);
			protocol_errors++;
		end
		else
			check_value("result", 1, result);
	endtask

	task automatic hash_and_predict(input byte_arr_t b, input logic held_result);
		shift_in_block(b);
		run_hash(held_result);
		block_to_bytes(romix(bytes_to_block(b)), exp_bytes);	// Reference result bytes
	endtask

	task automatic idle_after_reset();
		check_value("busy", 0, busy);
		check_value("result", 0, result);
		repeat (100)
		begin
			@(negedge hash_clk);
			check_value("busy", 0, busy);
			check_value("result", 0, result);
		end
	endtask

	task automatic zero_block_hash();
		for (int m = 0; m < NUM_BYTES; m++)
			in_bytes[m] = '0;
		hash_and_predict(in_bytes, 1'b0);
		shift_out_compare(exp_bytes);
	endtask

	task automatic random_block_hash();
		fill_random(in_bytes);
		hash_and_predict(in_bytes, 1'b1);
		shift_out_compare(exp_bytes);
	endtask

	// Previous result still flagged when the next block goes in
	task automatic back_to_back_hashes();
		check_value("result", 1, result);
		fill_random(in_bytes);
		shift_in_block(in_bytes);
		check_value("result", 1, result);
		run_hash(1'b1);
		block_to_bytes(romix(bytes_to_block(in_bytes)), exp_bytes);
		shift_out_compare(exp_bytes);
	endtask

	task automatic result_hold();
		fill_random(in_bytes);
		hash_and_predict(in_bytes, 1'b1);
		repeat (200)
		begin
			@(negedge hash_clk);
			check_value("result", 1, result);
			check_value("busy", 0, busy);
		end
		shift_out_compare(exp_bytes);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		hash_clk        = 1'b0;
		fsmreset        = 1'b1;
		din             = '0;
		shift           = 1'b0;
		start           = 1'b0;
		seed            = 32'h47c9_6f89;
		value_errors    = 0;
		protocol_errors = 0;
		repeat (5) @(negedge hash_clk);
		fsmreset = 1'b0;

		idle_after_reset();
		zero_block_hash();
		random_block_hash();
		back_to_back_hashes();
		result_hold();

		$display("Checks done: %0d value errors, %0d protocol errors, %0d assertion failures",
			value_errors, protocol_errors, dut_i.u_salsa_engine_assertions.failures);
		if (value_errors == 0 && protocol_errors == 0
			&& dut_i.u_salsa_engine_assertions.failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sources.f */
scrypt_pkg.sv
block_shifter.sv
salsa_core.sv
mix_datapath.sv
scratchpad_ram.sv
romix_ctrl.sv
salsa_engine.sv
salsa_engine_assertions.sv
tb_salsa_engine.sv

/* Bender.yml */
package:
  name: salsa_engine

sources:
  - scrypt_pkg.sv
  - block_shifter.sv
  - salsa_core.sv
  - mix_datapath.sv
  - scratchpad_ram.sv
  - romix_ctrl.sv
  - salsa_engine.sv
  - target: test
    files:
      - salsa_engine_assertions.sv
      - tb_salsa_engine.sv
